// File: dsp_pkg.sv
package dsp_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // sizes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int DATA_W     = 32;   // host write word
    localparam int CMD_W      = 128;  // one command is four host words
    localparam int CMD_ADDR_W = 6;
    localparam int ENV_ADDR_W = 10;
    localparam int ENV_LEN_W  = 10;
    localparam int ACC_ADDR_W = 8;
    localparam int ACC_W      = 32;
    localparam int SAMPLE_W   = 16;   // signed dac and adc samples
    localparam int TIME_W     = 16;   // shot timer and window lengths

    // fixed point scaling of envelope times amplitude
    localparam int AMP_SHIFT  = 15;
    localparam int PROD_W     = 2 * SAMPLE_W;

    typedef enum logic [2:0] {
        SEL_CMD = 3'd0,
        SEL_ENV = 3'd1
    } mem_sel_e;

    typedef enum logic [1:0] {
        OP_PULSE = 2'd0,
        OP_ACQ   = 2'd1,
        OP_END   = 2'd2
    } opcode_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // command word, opcode on top in both views
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int PULSE_PAD_W = CMD_W - 2 - TIME_W - ENV_ADDR_W - ENV_LEN_W - SAMPLE_W;
    localparam int ACQ_PAD_W   = CMD_W - 2 - 2 * TIME_W - ACC_ADDR_W;

    typedef struct packed {
        opcode_e                    opcode;
        logic [TIME_W-1:0]          start_time;
        logic [ENV_ADDR_W-1:0]      env_addr;
        logic [ENV_LEN_W-1:0]       env_len;
        logic signed [SAMPLE_W-1:0] amp;
        logic [PULSE_PAD_W-1:0]     pad;
    } pulse_cmd_t;

    typedef struct packed {
        opcode_e                    opcode;
        logic [TIME_W-1:0]          start_time;
        logic [TIME_W-1:0]          acq_len;
        logic [ACC_ADDR_W-1:0]      acc_base;
        logic [ACQ_PAD_W-1:0]       pad;
    } acq_cmd_t;

    typedef union packed {
        pulse_cmd_t pulse;
        acq_cmd_t   acq;
    } cmd_u;

endpackage

// File: aligned_ram.sv
`timescale 1ns/1ns

module aligned_ram #(
    parameter int DIN_WIDTH       = 32,
    parameter int N_DIN_TO_DOUT   = 4,
    parameter int DOUT_ADDR_WIDTH = 6,
    parameter int READ_LATENCY    = 2
) (
    input  logic                                          clk,
    input  logic [DIN_WIDTH-1:0]                          write_data,
    input  logic [DOUT_ADDR_WIDTH+$clog2(N_DIN_TO_DOUT)-1:0] write_addr,
    input  logic                                          write_enable,
    input  logic [DOUT_ADDR_WIDTH-1:0]                    read_addr,
    output logic [DIN_WIDTH*N_DIN_TO_DOUT-1:0]            read_data
);

    localparam int DOUT_WIDTH = DIN_WIDTH * N_DIN_TO_DOUT;
    localparam int DEPTH      = 2 ** DOUT_ADDR_WIDTH;
    localparam int LANE_W     = $clog2(N_DIN_TO_DOUT);
    localparam int SEL_W      = (LANE_W > 0) ? LANE_W : 1;

    logic [N_DIN_TO_DOUT-1:0][DIN_WIDTH-1:0] mem [DEPTH];
    logic [DOUT_WIDTH-1:0]                   rd_pipe [READ_LATENCY];
    logic [DOUT_ADDR_WIDTH-1:0]              wr_row;
    logic [SEL_W-1:0]                        wr_lane;

    // lane count is a power of two, so this is just the low address bits
    assign wr_lane = SEL_W'(write_addr % N_DIN_TO_DOUT);
    assign wr_row  = DOUT_ADDR_WIDTH'(write_addr / N_DIN_TO_DOUT);

    always_ff @(posedge clk) begin
        if (write_enable) begin
            mem[wr_row][wr_lane] <= write_data;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read pipeline
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        rd_pipe[0] <= mem[read_addr];
        for (int k = 1; k < READ_LATENCY; k++) begin
            rd_pipe[k] <= rd_pipe[k-1];
        end
    end

    assign read_data = rd_pipe[READ_LATENCY-1];  // lane 0 lands in the low bits

endmodule

// File: ifdsp.sv
`timescale 1ns/1ns

interface ifdsp import dsp_pkg::*; #(
    parameter int NPROC = 2
) ();

    // core side outputs, one entry per core
    logic [CMD_ADDR_W-1:0]      addr_command [NPROC];
    logic [ENV_ADDR_W-1:0]      addr_env     [NPROC];
    logic                       we_acc       [NPROC];
    logic [ACC_ADDR_W-1:0]      addr_acc     [NPROC];
    logic [ACC_W-1:0]           data_acc     [NPROC];
    logic signed [SAMPLE_W-1:0] dac          [NPROC];

    // memory side outputs
    cmd_u                       data_command [NPROC];
    logic [DATA_W-1:0]          data_env     [NPROC];
    logic signed [SAMPLE_W-1:0] adc          [NPROC];
    logic                       stb_start;   // shared by all cores
    logic [15:0]                nshot;

    modport dsp (
        output addr_command, addr_env,
        output we_acc, addr_acc, data_acc,
        output dac,
        input  data_command, data_env,
        input  adc, stb_start, nshot
    );

    modport mem (
        input  addr_command, addr_env,
        input  we_acc, addr_acc, data_acc,
        input  dac,
        output data_command, data_env,
        output adc, stb_start, nshot
    );

endinterface

// File: pulse_core.sv
`timescale 1ns/1ns

module pulse_core import dsp_pkg::*; (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       stb_start,
    input  logic [15:0]                nshot,
    output logic [CMD_ADDR_W-1:0]      cmd_addr,
    input  cmd_u                       cmd_data,
    output logic [ENV_ADDR_W-1:0]      env_addr,
    input  logic [DATA_W-1:0]          env_data,
    input  logic signed [SAMPLE_W-1:0] adc,
    output logic signed [SAMPLE_W-1:0] dac,
    output logic                       acc_we,
    output logic [ACC_ADDR_W-1:0]      acc_addr,
    output logic [ACC_W-1:0]           acc_data,
    output logic                       busy
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_FETCH,
        S_EXEC
    } state_e;

    state_e                     state;
    logic                       fetch_cnt;
    logic [TIME_W-1:0]          shot_time;
    logic [15:0]                shot_cnt;
    logic [15:0]                nshot_q;
    opcode_e                    op;
    logic                       pulse_busy, acq_busy;
    logic                       pulse_issue, acq_issue, end_go;
    logic                       env_rd;
    logic [ENV_ADDR_W-1:0]      env_ptr;
    logic [ENV_LEN_W-1:0]       play_cnt;
    logic [1:0]                 rd_valid;
    logic signed [SAMPLE_W-1:0] amp_q;
    logic signed [SAMPLE_W-1:0] env_s;
    logic signed [PROD_W-1:0]   prod;
    logic [TIME_W-1:0]          acq_cnt;
    logic [ACC_W-1:0]           acc_sum;

    // cmd_data stays valid in S_EXEC because cmd_addr only moves on leaving it
    assign op = cmd_data.pulse.opcode;

    assign pulse_busy  = (play_cnt != '0) || (rd_valid != '0);
    assign acq_busy    = (acq_cnt != '0) || acc_we;
    assign pulse_issue = (state == S_EXEC) && (op == OP_PULSE) && !pulse_busy &&
                         (shot_time >= cmd_data.pulse.start_time);
    assign acq_issue   = (state == S_EXEC) && (op == OP_ACQ) && !acq_busy &&
                         (shot_time >= cmd_data.acq.start_time);
    // an unknown opcode ends the shot as well
    assign end_go      = (state == S_EXEC) && (op != OP_PULSE) && (op != OP_ACQ) &&
                         !pulse_busy && !acq_busy;

    assign busy = (state != S_IDLE);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // command sequencer
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= S_IDLE;
            cmd_addr  <= '0;
            fetch_cnt <= 1'b0;
            shot_time <= '0;
            shot_cnt  <= '0;
            nshot_q   <= '0;
        end else begin
            if (shot_time != '1) begin
                shot_time <= shot_time + 1'b1;  // saturates on very long shots
            end
            case (state)
                S_IDLE: begin
                    if (stb_start && (nshot != '0)) begin
                        state     <= S_FETCH;
                        cmd_addr  <= '0;
                        shot_time <= '0;
                        shot_cnt  <= '0;
                        nshot_q   <= nshot;
                    end
                end
                S_FETCH: begin
                    // two cycles of command memory latency
                    fetch_cnt <= ~fetch_cnt;
                    if (fetch_cnt) begin
                        state <= S_EXEC;
                    end
                end
                S_EXEC: begin
                    if (pulse_issue || acq_issue) begin
                        cmd_addr <= cmd_addr + 1'b1;
                        state    <= S_FETCH;
                    end else if (end_go) begin
                        cmd_addr <= '0;
                        if (shot_cnt + 1 < nshot_q) begin
                            shot_cnt  <= shot_cnt + 1'b1;
                            shot_time <= '0;
                            state     <= S_FETCH;
                        end else begin
                            state <= S_IDLE;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // envelope player
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // the first address goes out in the issue cycle so sample 0 lands 3 cycles later
    assign env_rd   = (pulse_issue && (cmd_data.pulse.env_len != '0)) || (play_cnt != '0);
    assign env_addr = pulse_issue ? cmd_data.pulse.env_addr : env_ptr;
    assign env_s    = signed'(env_data[SAMPLE_W-1:0]);  // upper half of the word is spare
    assign prod     = env_s * amp_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            play_cnt <= '0;
            rd_valid <= '0;
            dac      <= '0;
        end else begin
            rd_valid <= {rd_valid[0], env_rd};
            dac      <= rd_valid[1] ? SAMPLE_W'(prod >>> AMP_SHIFT) : '0;
            if (pulse_issue && (cmd_data.pulse.env_len != '0)) begin
                play_cnt <= cmd_data.pulse.env_len - 1'b1;
            end else if (play_cnt != '0) begin
                play_cnt <= play_cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pulse_issue) begin
            env_ptr <= cmd_data.pulse.env_addr + 1'b1;
            amp_q   <= cmd_data.pulse.amp;
        end else if (play_cnt != '0) begin
            env_ptr <= env_ptr + 1'b1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // acquisition accumulator
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (rst) begin
            acq_cnt <= '0;
            acc_we  <= 1'b0;
        end else begin
            acc_we <= (acq_cnt == TIME_W'(1));  // last window cycle, write next
            if (acq_issue) begin
                acq_cnt <= cmd_data.acq.acq_len;
            end else if (acq_cnt != '0) begin
                acq_cnt <= acq_cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (acq_issue) begin
            acc_sum  <= '0;
            acc_addr <= cmd_data.acq.acc_base + shot_cnt[ACC_ADDR_W-1:0];
        end else if (acq_cnt != '0) begin
            acc_sum <= acc_sum + ACC_W'(adc);
        end
    end

    assign acc_data = acc_sum;

endmodule

// File: dsp.sv
`timescale 1ns/1ns

module dsp #(
    parameter int NPROC = 2
) (
    input  logic             clk,
    input  logic             rst,
    ifdsp.dsp                dspif,
    output logic [NPROC-1:0] busy
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // one sequencer per core
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    for (genvar i = 0; i < NPROC; i++) begin : g_core
        // start and shot count are common, everything else is per core
        pulse_core u_core (
            .clk       (clk),
            .rst       (rst),
            .stb_start (dspif.stb_start),
            .nshot     (dspif.nshot),
            .cmd_addr  (dspif.addr_command[i]),
            .cmd_data  (dspif.data_command[i]),
            .env_addr  (dspif.addr_env[i]),
            .env_data  (dspif.data_env[i]),
            .adc       (dspif.adc[i]),   // core i owns adc channel i
            .dac       (dspif.dac[i]),
            .acc_we    (dspif.we_acc[i]),
            .acc_addr  (dspif.addr_acc[i]),
            .acc_data  (dspif.data_acc[i]),
            .busy      (busy[i])
        );
    end

endmodule

// File: dsp_sim_toplevel.sv
`timescale 1ns/1ns

module dsp_sim_toplevel import dsp_pkg::*; #(
    parameter int NPROC = 2
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       stb_start,
    input  logic [15:0]                nshot,
    input  logic [DATA_W-1:0]          mem_write_data,
    input  logic [15:0]                mem_write_addr,
    input  logic [2:0]                 proc_write_sel,  // core index
    input  logic [2:0]                 mem_write_sel,   // see mem_sel_e
    input  logic                       mem_write_en,
    input  logic [ACC_ADDR_W-1:0]      buf_read_addr,
    input  logic signed [SAMPLE_W-1:0] adc [NPROC],
    output logic signed [SAMPLE_W-1:0] dac [NPROC],
    output logic [ACC_W-1:0]           acc_read_data [NPROC],
    output logic                       busy
);

    localparam int CMD_LANES   = CMD_W / DATA_W;
    localparam int CMD_WADDR_W = CMD_ADDR_W + $clog2(CMD_LANES);

    logic [NPROC-1:0] core_busy;

    ifdsp #(.NPROC(NPROC)) dspif ();

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // per core memories
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    for (genvar i = 0; i < NPROC; i++) begin : g_proc
        logic core_sel;
        logic cmd_wen;
        logic env_wen;

        assign core_sel = mem_write_en && (proc_write_sel == 3'(i));
        assign cmd_wen  = core_sel && (mem_write_sel == SEL_CMD);
        assign env_wen  = core_sel && (mem_write_sel == SEL_ENV);

        // four host words make one command, word 0 is the low lane
        aligned_ram #(.DIN_WIDTH(DATA_W), .N_DIN_TO_DOUT(CMD_LANES),
                      .DOUT_ADDR_WIDTH(CMD_ADDR_W), .READ_LATENCY(2))
            u_cmd_mem (.clk(clk), .write_data(mem_write_data),
                       .write_addr(mem_write_addr[CMD_WADDR_W-1:0]), .write_enable(cmd_wen),
                       .read_addr(dspif.addr_command[i]), .read_data(dspif.data_command[i]));

        aligned_ram #(.DIN_WIDTH(DATA_W), .N_DIN_TO_DOUT(1),
                      .DOUT_ADDR_WIDTH(ENV_ADDR_W), .READ_LATENCY(2))
            u_env_mem (.clk(clk), .write_data(mem_write_data),
                       .write_addr(mem_write_addr[ENV_ADDR_W-1:0]), .write_enable(env_wen),
                       .read_addr(dspif.addr_env[i]), .read_data(dspif.data_env[i]));

        // written by the core, read back by the host
        aligned_ram #(.DIN_WIDTH(ACC_W), .N_DIN_TO_DOUT(1),
                      .DOUT_ADDR_WIDTH(ACC_ADDR_W), .READ_LATENCY(1))
            u_acc_buf (.clk(clk), .write_data(dspif.data_acc[i]),
                       .write_addr(dspif.addr_acc[i]), .write_enable(dspif.we_acc[i]),
                       .read_addr(buf_read_addr), .read_data(acc_read_data[i]));
    end

    assign dspif.adc       = adc;
    assign dspif.stb_start = stb_start;
    assign dspif.nshot     = nshot;
    assign dac             = dspif.dac;

    dsp #(.NPROC(NPROC)) u_dsp (
        .clk   (clk),
        .rst   (rst),
        .dspif (dspif.dsp),
        .busy  (core_busy)
    );

    assign busy = |core_busy;  // high while any core still runs

endmodule

// File: dsp_checker.sv
`timescale 1ns/1ns

module dsp_checker import dsp_pkg::*; (
    input logic                       clk,
    input logic                       rst,
    input logic                       busy,
    input logic signed [SAMPLE_W-1:0] dac,
    input logic                       acc_we,
    input opcode_e                    op
);

    int fail_cnt = 0;  // read by the testbench at the end of the run

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // idle core is silent
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    a_dac_idle: assert property (@(posedge clk) disable iff (rst) !busy |-> (dac == '0))
        else begin
            $error("dac nonzero while the core is idle");
            fail_cnt++;
        end

    a_acc_idle: assert property (@(posedge clk) disable iff (rst) !busy |-> !acc_we)
        else begin
            $error("accumulator write while the core is idle");
            fail_cnt++;
        end

    // the command in execution on the last busy cycle must be the end marker
    a_end_only: assert property (@(posedge clk) disable iff (rst)
                                 $fell(busy) |-> ($past(op) == OP_END))
        else begin
            $error("busy fell without an end command");
            fail_cnt++;
        end

endmodule

bind pulse_core dsp_checker u_checker (
    .clk    (clk),
    .rst    (rst),
    .busy   (busy),
    .dac    (dac),
    .acc_we (acc_we),
    .op     (op)
);

// File: tb_dsp_sim_toplevel.sv
`timescale 1ns/1ns

module tb_dsp_sim_toplevel import dsp_pkg::*; ();

    localparam int NPROC      = 2;
    localparam int WAIT_LIMIT = 3000;  // cycles allowed for any single wait

    logic                       clk;
    logic                       rst;
    logic                       stb_start;
    logic [15:0]                nshot;
    logic [DATA_W-1:0]          mem_write_data;
    logic [15:0]                mem_write_addr;
    logic [2:0]                 proc_write_sel;
    logic [2:0]                 mem_write_sel;
    logic                       mem_write_en;
    logic [ACC_ADDR_W-1:0]      buf_read_addr;
    logic signed [SAMPLE_W-1:0] adc [NPROC];
    logic signed [SAMPLE_W-1:0] dac [NPROC];
    logic [ACC_W-1:0]           acc_read_data [NPROC];
    logic                       busy;

    int                         value_errs;
    int                         timeout_errs;
    int                         assert_fails;
    int                         pulses0;
    logic [31:0]                lfsr_state;
    logic signed [SAMPLE_W-1:0] exp0 [$];
    logic signed [SAMPLE_W-1:0] exp1 [$];
    logic signed [SAMPLE_W-1:0] got0 [$];
    logic signed [SAMPLE_W-1:0] got1 [$];

    dsp_sim_toplevel #(.NPROC(NPROC)) DUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // taps 32, 22, 2, 1 give a maximal length sequence
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int k = 0; k < n; k++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            v          = {v[30:0], fb};
        end
        return v;
    endfunction

    // magnitude in [2**mag_w, 2**(mag_w+1)), random sign, never zero
    function automatic logic signed [SAMPLE_W-1:0] rand_signed(input int mag_w);
        logic signed [SAMPLE_W-1:0] v;
        v = SAMPLE_W'((1 << mag_w) + rand_bits(mag_w));
        if (rand_bits(1) != 0) begin
            v = -v;
        end
        return v;
    endfunction

    function automatic logic signed [SAMPLE_W-1:0] scaled(input logic signed [SAMPLE_W-1:0] env,
                                                          input logic signed [SAMPLE_W-1:0] amp);
        logic signed [31:0] p;
        p = env * amp;
        return SAMPLE_W'(p >>> AMP_SHIFT);
    endfunction

    function automatic cmd_u pulse_cmd(input int start, input int addr, input int len,
                                       input logic signed [SAMPLE_W-1:0] amp);
        cmd_u c;
        c                  = '0;
        c.pulse.opcode     = OP_PULSE;
        c.pulse.start_time = TIME_W'(start);
        c.pulse.env_addr   = ENV_ADDR_W'(addr);
        c.pulse.env_len    = ENV_LEN_W'(len);
        c.pulse.amp        = amp;
        return c;
    endfunction

    function automatic cmd_u acq_cmd(input int start, input int len, input int base);
        cmd_u c;
        c                = '0;
        c.acq.opcode     = OP_ACQ;
        c.acq.start_time = TIME_W'(start);
        c.acq.acq_len    = TIME_W'(len);
        c.acq.acc_base   = ACC_ADDR_W'(base);
        return c;
    endfunction

    function automatic cmd_u end_cmd();
        cmd_u c;
        c              = '0;
        c.pulse.opcode = OP_END;
        return c;
    endfunction

    task automatic write_word(input int core, input mem_sel_e sel, input int addr,
                              input logic [31:0] data);
        @(negedge clk);
        proc_write_sel = 3'(core);
        mem_write_sel  = sel;
        mem_write_addr = 16'(addr);
        mem_write_data = data;
        mem_write_en   = 1'b1;
        @(negedge clk);
        mem_write_en   = 1'b0;
    endtask

    task automatic write_cmd(input int core, input int idx, input cmd_u c);
        for (int k = 0; k < CMD_W / DATA_W; k++) begin
            write_word(core, SEL_CMD, idx * 4 + k, c[32*k +: 32]);  // word 0 is the low lane
        end
    endtask

    // random envelope, expected dac samples go to the core's queue
    task automatic load_envelope(input int core, input int base, input int len,
                                 input logic signed [SAMPLE_W-1:0] amp);
        logic signed [SAMPLE_W-1:0] s;
        for (int k = 0; k < len; k++) begin
            s = rand_signed(12);
            write_word(core, SEL_ENV, base + k, {16'h0000, s});
            if (core == 0) begin
                exp0.push_back(scaled(s, amp));
            end else begin
                exp1.push_back(scaled(s, amp));
            end
        end
    endtask

    task automatic start_run(input int n);
        @(negedge clk);
        nshot     = 16'(n);
        stb_start = 1'b1;
        @(negedge clk);
        stb_start = 1'b0;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic check_sample(input string name, input logic signed [SAMPLE_W-1:0] got,
                                input logic signed [SAMPLE_W-1:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s: got %0d, expected %0d", $time, name, got, exp);
            value_errs++;
        end
    endtask

    task automatic check_acc(input string name, input logic [ACC_W-1:0] got,
                             input logic [ACC_W-1:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s: got %0d, expected %0d", $time, name,
                     $signed(got), $signed(exp));
            value_errs++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s: got %b, expected %b", $time, name, got, exp);
            value_errs++;
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("[ERROR] %0t %s: got %0d, expected %0d", $time, name, got, exp);
            value_errs++;
        end
    endtask

    task automatic wait_idle();
        int t;
        t = 0;
        while (busy !== 1'b0 && t < WAIT_LIMIT) begin
            @(negedge clk);
            t++;
        end
        if (busy !== 1'b0) begin
            $display("timeout at %0t: busy never fell", $time);
            timeout_errs++;
        end
    endtask

    // records every nonzero dac sample and counts pulses on core 0 until busy falls
    task automatic collect_run();
        int                         t;
        logic signed [SAMPLE_W-1:0] prev0;
        t       = 0;
        prev0   = '0;
        pulses0 = 0;
        got0.delete();
        got1.delete();
        do begin
            @(negedge clk);
            if (dac[0] != 0) begin
                got0.push_back(dac[0]);
            end
            if (dac[1] != 0) begin
                got1.push_back(dac[1]);
            end
            if (dac[0] != 0 && prev0 == 0) begin
                pulses0++;
            end
            prev0 = dac[0];
            t++;
        end while (busy !== 1'b0 && t < WAIT_LIMIT);
        if (busy !== 1'b0) begin
            $display("timeout at %0t: run did not finish", $time);
            timeout_errs++;
        end
    endtask

    task automatic compare_samples(input int core);
        int n_exp;
        int n_got;
        n_exp = (core == 0) ? exp0.size() : exp1.size();
        n_got = (core == 0) ? got0.size() : got1.size();
        check_count($sformatf("dac[%0d] sample count", core), n_got, n_exp);
        for (int k = 0; k < n_exp && k < n_got; k++) begin
            check_sample($sformatf("dac[%0d] sample %0d", core, k),
                         (core == 0) ? got0[k] : got1[k], (core == 0) ? exp0[k] : exp1[k]);
        end
    endtask

    task automatic read_acc(input int core, input int addr, input logic [ACC_W-1:0] exp);
        @(negedge clk);
        buf_read_addr = ACC_ADDR_W'(addr);
        @(negedge clk);  // one cycle of buffer latency
        check_acc($sformatf("acc_read_data[%0d] entry %0d", core, addr),
                  acc_read_data[core], exp);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // directed tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic test_reset();
        check_flag("busy", busy, 1'b0);
        check_sample("dac[0]", dac[0], '0);
        check_sample("dac[1]", dac[1], '0);
    endtask

    task automatic test_single_pulse();
        logic signed [SAMPLE_W-1:0] amp;
        int                         t;
        amp = rand_signed(13);
        exp0.delete();
        load_envelope(0, 16, 6, amp);
        write_cmd(0, 0, pulse_cmd(5, 16, 6, amp));
        write_cmd(0, 1, end_cmd());
        write_cmd(1, 0, end_cmd());  // core 1 shares the start strobe
        start_run(1);
        t = 0;
        while (dac[0] == 0 && t < WAIT_LIMIT) begin
            @(negedge clk);
            t++;
        end
        if (dac[0] == 0) begin
            $display("timeout at %0t: no pulse sample on dac[0]", $time);
            timeout_errs++;
        end else begin
            for (int k = 0; k < 6; k++) begin
                check_sample($sformatf("dac[0] sample %0d", k), dac[0], exp0[k]);
                @(negedge clk);
            end
            check_sample("dac[0] after pulse", dac[0], '0);
        end
        wait_idle();
    endtask

    task automatic test_acquire();
        logic signed [SAMPLE_W-1:0] a0;
        a0     = rand_signed(10);
        adc[0] = a0;
        write_cmd(0, 0, acq_cmd(4, 9, 20));
        write_cmd(0, 1, end_cmd());
        write_cmd(1, 0, end_cmd());
        start_run(3);
        wait_idle();
        for (int s = 0; s < 3; s++) begin
            read_acc(0, 20 + s, ACC_W'(int'(a0) * 9));
        end
    endtask

    task automatic test_two_cores();
        logic signed [SAMPLE_W-1:0] amp0;
        logic signed [SAMPLE_W-1:0] amp1;
        logic signed [SAMPLE_W-1:0] a0;
        logic signed [SAMPLE_W-1:0] a1;
        amp0   = rand_signed(13);
        amp1   = rand_signed(13);
        a0     = rand_signed(10);
        a1     = rand_signed(10);
        adc[0] = a0;
        adc[1] = a1;
        exp0.delete();
        exp1.delete();
        load_envelope(0, 100, 4, amp0);
        load_envelope(1, 200, 3, amp1);
        write_cmd(0, 0, pulse_cmd(2, 100, 4, amp0));
        write_cmd(0, 1, acq_cmd(3, 5, 40));
        write_cmd(0, 2, end_cmd());
        write_cmd(1, 0, acq_cmd(0, 7, 60));  // core 1 acquires first
        write_cmd(1, 1, pulse_cmd(8, 200, 3, amp1));
        write_cmd(1, 2, end_cmd());
        start_run(1);
        collect_run();
        compare_samples(0);
        compare_samples(1);
        read_acc(0, 40, ACC_W'(int'(a0) * 5));
        read_acc(1, 60, ACC_W'(int'(a1) * 7));
    endtask

    task automatic test_restart_ignored();
        logic signed [SAMPLE_W-1:0] amp;
        amp = rand_signed(13);
        exp0.delete();
        load_envelope(0, 300, 4, amp);
        write_cmd(0, 0, pulse_cmd(3, 300, 4, amp));
        write_cmd(0, 1, end_cmd());
        write_cmd(1, 0, end_cmd());
        start_run(3);
        check_flag("busy before second start", busy, 1'b1);
        start_run(5);  // a restart that got through would play five pulses
        collect_run();
        check_count("pulses on dac[0]", pulses0, 3);
    endtask

    initial begin
        lfsr_state     = 32'h92751702;
        value_errs     = 0;
        timeout_errs   = 0;
        rst            = 1'b1;
        stb_start      = 1'b0;
        nshot          = '0;
        mem_write_data = '0;
        mem_write_addr = '0;
        proc_write_sel = '0;
        mem_write_sel  = '0;
        mem_write_en   = 1'b0;
        buf_read_addr  = '0;
        for (int i = 0; i < NPROC; i++) begin
            adc[i] = '0;
        end
        repeat (16) @(negedge clk);
        rst = 1'b0;

        test_reset();
        test_single_pulse();
        test_acquire();
        test_two_cores();
        test_restart_ignored();

        assert_fails = DUT.u_dsp.g_core[0].u_core.u_checker.fail_cnt +
                       DUT.u_dsp.g_core[1].u_core.u_checker.fail_cnt;
        $display("error counts: %0d value, %0d timeout, %0d assertion",
                 value_errs, timeout_errs, assert_fails);
        if (value_errs == 0 && timeout_errs == 0 && assert_fails == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: filelist.f
dsp_pkg.sv
aligned_ram.sv
ifdsp.sv
pulse_core.sv
dsp.sv
dsp_sim_toplevel.sv
dsp_checker.sv
tb_dsp_sim_toplevel.sv

// File: Bender.yml
package:
  name: dsp_sim

sources:
  - dsp_pkg.sv
  - aligned_ram.sv
  - ifdsp.sv
  - pulse_core.sv
  - dsp.sv
  - dsp_sim_toplevel.sv
  - target: simulation
    files:
      - dsp_checker.sv
      - tb_dsp_sim_toplevel.sv
